// ==== erx.f ====
+incdir+.
erx_packet_pkg.sv
erx_ctrl_pkg.sv
erx_if.sv
erx_protocol.sv
erx_mmu.sv
erx_disty.sv
erx_fifo.sv
erx.sv
tb_erx.sv

// ==== erx.sv ====
`timescale 1ns/1ps
`default_nettype none

module erx (
   input  logic                                   rx_lclk_div4,
   input  logic                                   reset,
   input  logic                                   ecfg_rx_enable,
   input  logic                                   ecfg_rx_mmu_enable,
   input  logic [7:0]                             rx_frame_par,
   input  logic [63:0]                            rx_data_par,
   input  logic                                   mi_en,
   input  logic                                   mi_we,
   input  logic [3:0]                             mi_addr,
   input  logic [31:0]                            mi_din,
   output logic [31:0]                            mi_dout,
   output logic                                   rx_wr_wait,
   output logic                                   rx_rd_wait,
   input  logic                                   emaxi_emwr_rd_en,   // Write queue
   output logic                                   emaxi_emwr_empty,
   output logic [erx_packet_pkg::PACKET_W-1:0]    emaxi_emwr_rd_data,
   input  logic                                   emaxi_emrq_rd_en,   // Read request queue
   output logic                                   emaxi_emrq_empty,
   output logic [erx_packet_pkg::PACKET_W-1:0]    emaxi_emrq_rd_data,
   input  logic                                   esaxi_emrr_rd_en,   // Read response queue
   output logic                                   esaxi_emrr_empty,
   output logic [erx_packet_pkg::PACKET_W-1:0]    esaxi_emrr_rd_data
);

   logic emesh_rx_wr_wait;                  // Distributor to decoder
   logic emesh_rx_rd_wait;

   emesh_if    emesh_rx ();                 // Decoder output
   emesh_if    emesh_mmu ();                // Translated stream
   queue_wr_if wr_q ();
   queue_wr_if rq_q ();
   queue_wr_if rr_q ();

   erx_protocol erx_protocol (
      .rx_lclk_div4     (rx_lclk_div4),
      .reset            (reset),
      .ecfg_rx_enable   (ecfg_rx_enable),
      .rx_frame_par     (rx_frame_par),
      .rx_data_par      (rx_data_par),
      .emesh_rx_wr_wait (emesh_rx_wr_wait),
      .emesh_rx_rd_wait (emesh_rx_rd_wait),
      .emesh            (emesh_rx),
      .rx_wr_wait       (rx_wr_wait),
      .rx_rd_wait       (rx_rd_wait)
   );

   erx_mmu erx_mmu (
      .rx_lclk_div4       (rx_lclk_div4),
      .reset              (reset),
      .ecfg_rx_mmu_enable (ecfg_rx_mmu_enable),
      .mi_en              (mi_en),
      .mi_we              (mi_we),
      .mi_addr            (mi_addr),
      .mi_din             (mi_din),
      .mi_dout            (mi_dout),
      .emesh_in           (emesh_rx),
      .emesh_out          (emesh_mmu)
   );

   erx_disty erx_disty (
      .emesh            (emesh_mmu),
      .wr_q             (wr_q),
      .rq_q             (rq_q),
      .rr_q             (rr_q),
      .emesh_rx_wr_wait (emesh_rx_wr_wait),
      .emesh_rx_rd_wait (emesh_rx_rd_wait)
   );

   erx_fifo m_wr_fifo (
      .rx_lclk_div4 (rx_lclk_div4),
      .reset        (reset),
      .wr           (wr_q),
      .rd_en        (emaxi_emwr_rd_en),
      .empty        (emaxi_emwr_empty),
      .rd_data      (emaxi_emwr_rd_data)
   );

   erx_fifo m_rq_fifo (
      .rx_lclk_div4 (rx_lclk_div4),
      .reset        (reset),
      .wr           (rq_q),
      .rd_en        (emaxi_emrq_rd_en),
      .empty        (emaxi_emrq_empty),
      .rd_data      (emaxi_emrq_rd_data)
   );

   erx_fifo s_rr_fifo (
      .rx_lclk_div4 (rx_lclk_div4),
      .reset        (reset),
      .wr           (rr_q),
      .rd_en        (esaxi_emrr_rd_en),
      .empty        (esaxi_emrr_empty),
      .rd_data      (esaxi_emrr_rd_data)
   );

endmodule

`default_nettype wire

// ==== erx_ctrl_pkg.sv ====
`default_nettype none

package erx_ctrl_pkg;

   // Pin decoder states
   typedef enum logic [1:0] {
      IDLE  = 2'd0,                // Waiting for beat A
      BEAT2 = 2'd1,                // Beat A held, expecting beat B
      GAP   = 2'd2                 // Packet done, wait for frame low
   } rx_state_t;

   // Destination queue of a transaction
   typedef enum logic [1:0] {
      Q_WR = 2'd0,                 // Plain writes
      Q_RQ = 2'd1,                 // Read requests
      Q_RR = 2'd2                  // Read responses
   } queue_sel_t;

endpackage

`default_nettype wire

// ==== erx_disty.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "erx_settings.svh"

module erx_disty (
   emesh_if.dst   emesh,
   queue_wr_if.wr wr_q,                     // Host-bound writes
   queue_wr_if.wr rq_q,                     // Read requests
   queue_wr_if.wr rr_q,                     // Read responses
   output logic   emesh_rx_wr_wait,
   output logic   emesh_rx_rd_wait
);
   import erx_packet_pkg::*;
   import erx_ctrl_pkg::*;

   queue_sel_t    sel;
   emesh_packet_t packet;

   // Queue decision
   always_comb
   begin
      if (!emesh.write)
         sel = Q_RQ;                        // Any read
      else if (emesh.dstaddr[31:20] == `ERX_RR_ID)
         sel = Q_RR;                        // Response window
      else
         sel = Q_WR;
   end

   // Entry format shared by all queues
   always_comb
   begin
      packet.write    = emesh.write;
      packet.datamode = emesh.datamode;
      packet.ctrlmode = emesh.ctrlmode;
      packet.dstaddr  = emesh.dstaddr;
      packet.data     = emesh.data;
      packet.srcaddr  = emesh.srcaddr;
   end

   assign wr_q.wr_data = packet;
   assign rq_q.wr_data = packet;
   assign rr_q.wr_data = packet;

   // Only the chosen queue sees the strobe; dropped if full
   assign wr_q.wr_en = emesh.access && (sel == Q_WR) && !wr_q.full;
   assign rq_q.wr_en = emesh.access && (sel == Q_RQ) && !rq_q.full;
   assign rr_q.wr_en = emesh.access && (sel == Q_RR) && !rr_q.full;

   // Writes and responses share the write wait
   assign emesh_rx_wr_wait = wr_q.prog_full | rr_q.prog_full;
   assign emesh_rx_rd_wait = rq_q.prog_full;

endmodule

`default_nettype wire

// ==== erx_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "erx_settings.svh"

module erx_fifo (
   input  logic                          rx_lclk_div4,
   input  logic                          reset,
   queue_wr_if.q                         wr,
   input  logic                          rd_en,    // Pop head
   output logic                          empty,
   output erx_packet_pkg::emesh_packet_t rd_data   // Head, valid when not empty
);
   import erx_packet_pkg::*;

   localparam int DEPTH = `ERX_FIFO_DEPTH;
   localparam int PTR_W = $clog2(DEPTH);
   localparam int CNT_W = $clog2(DEPTH + 1);       // Holds 0..DEPTH

   emesh_packet_t    mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;                        // Occupancy
   logic             push;
   logic             pop;

   function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
      return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1; // Wrap for any depth
   endfunction

   assign push         = wr.wr_en && !wr.full;
   assign pop          = rd_en && !empty;           // Pop on empty ignored
   assign empty        = (count == '0);
   assign wr.full      = (count == CNT_W'(DEPTH));
   assign wr.prog_full = (count >= CNT_W'(`ERX_PROGFULL_LEVEL));
   assign rd_data      = mem[rd_ptr];               // Fall-through head

   always_ff @(posedge rx_lclk_div4)
   begin
      if (push)
         mem[wr_ptr] <= wr.wr_data;
   end

   always_ff @(posedge rx_lclk_div4)
   begin
      if (reset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (push)
            wr_ptr <= ptr_next(wr_ptr);
         if (pop)
            rd_ptr <= ptr_next(rd_ptr);
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;         // Idle or simultaneous push/pop
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== erx_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// Transaction bus between pipeline stages
interface emesh_if;
   import erx_packet_pkg::*;

   logic              access;      // One-cycle strobe
   logic              write;
   datamode_t         datamode;
   logic [CTRL_W-1:0] ctrlmode;
   logic [ADDR_W-1:0] dstaddr;
   logic [ADDR_W-1:0] srcaddr;
   logic [DATA_W-1:0] data;

   modport src (
      output access, write, datamode, ctrlmode, dstaddr, srcaddr, data
   );

   modport dst (
      input access, write, datamode, ctrlmode, dstaddr, srcaddr, data
   );
endinterface

// Push side of one receive queue
interface queue_wr_if;
   import erx_packet_pkg::*;

   logic          wr_en;           // Push strobe
   emesh_packet_t wr_data;
   logic          full;            // No room left
   logic          prog_full;       // Occupancy at threshold

   modport wr (
      output wr_en, wr_data,
      input  full, prog_full
   );

   modport q (
      input  wr_en, wr_data,
      output full, prog_full
   );
endinterface

`default_nettype wire

// ==== erx_mmu.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "erx_settings.svh"

module erx_mmu (
   input  logic        rx_lclk_div4,
   input  logic        reset,
   input  logic        ecfg_rx_mmu_enable,  // Translate dstaddr when set
   input  logic        mi_en,               // Host table access
   input  logic        mi_we,
   input  logic [3:0]  mi_addr,             // Table entry
   input  logic [31:0] mi_din,              // Only 11:0 stored
   output logic [31:0] mi_dout,             // Readback, zero-extended
   emesh_if.dst        emesh_in,
   emesh_if.src        emesh_out
);

   logic [11:0] mmu_table [`ERX_MMU_ENTRIES]; // New dstaddr[31:20] per region
   logic [11:0] entry;                        // Lookup for current transaction

   assign entry = mmu_table[emesh_in.dstaddr[31:28]];

   // Host writes
   always_ff @(posedge rx_lclk_div4)
   begin
      if (mi_en && mi_we)
         mmu_table[mi_addr] <= mi_din[11:0];
   end

   // Host readback
   always_ff @(posedge rx_lclk_div4)
   begin
      if (reset)
         mi_dout <= 32'd0;
      else if (mi_en && !mi_we)
         mi_dout <= {20'd0, mmu_table[mi_addr]};
   end

   // Strobe stage
   always_ff @(posedge rx_lclk_div4)
   begin
      if (reset)
         emesh_out.access <= 1'b0;
      else
         emesh_out.access <= emesh_in.access;
   end

   // Payload stage, dstaddr remapped on the fly
   always_ff @(posedge rx_lclk_div4)
   begin
      emesh_out.write    <= emesh_in.write;
      emesh_out.datamode <= emesh_in.datamode;
      emesh_out.ctrlmode <= emesh_in.ctrlmode;
      emesh_out.srcaddr  <= emesh_in.srcaddr;
      emesh_out.data     <= emesh_in.data;
      if (ecfg_rx_mmu_enable)
         emesh_out.dstaddr <= {entry, emesh_in.dstaddr[19:0]}; // Keep offset in region
      else
         emesh_out.dstaddr <= emesh_in.dstaddr;
   end

endmodule

`default_nettype wire

// ==== erx_packet_pkg.sv ====
`default_nettype none

package erx_packet_pkg;

   localparam int CTRL_W   = 4;                                    // Ctrlmode width
   localparam int ADDR_W   = 32;                                   // Dst/src address width
   localparam int DATA_W   = 32;                                   // Payload width
   localparam int PACKET_W = 1 + 2 + CTRL_W + ADDR_W + DATA_W + ADDR_W; // 103 bits

   // Access size of a transaction
   typedef enum logic [1:0] {
      DM_BYTE   = 2'b00,                                           // 8 bit
      DM_HALF   = 2'b01,                                           // 16 bit
      DM_WORD   = 2'b10,                                           // 32 bit
      DM_DOUBLE = 2'b11                                            // 64 bit, two beats upstream
   } datamode_t;

   // Queue entry, MSB first
   typedef struct packed {
      logic              write;                                    // 1 = write, 0 = read request
      datamode_t         datamode;
      logic [CTRL_W-1:0] ctrlmode;
      logic [ADDR_W-1:0] dstaddr;
      logic [DATA_W-1:0] data;
      logic [ADDR_W-1:0] srcaddr;                                  // Return address for reads
   } emesh_packet_t;

endpackage

`default_nettype wire

// ==== erx_protocol.sv ====
`timescale 1ns/1ps
`default_nettype none

module erx_protocol (
   input  logic        rx_lclk_div4,
   input  logic        reset,
   input  logic        ecfg_rx_enable,      // Receiver on
   input  logic [7:0]  rx_frame_par,        // One frame bit per byte lane
   input  logic [63:0] rx_data_par,         // Deserialized pin data
   input  logic        emesh_rx_wr_wait,    // From distributor
   input  logic        emesh_rx_rd_wait,
   emesh_if.src        emesh,
   output logic        rx_wr_wait,          // Back to the sender
   output logic        rx_rd_wait
);
   import erx_ctrl_pkg::*;
   import erx_packet_pkg::*;

   rx_state_t state;
   logic      frame_hi;                     // All lanes framed
   logic      beat_a;                       // Header beat accepted
   logic      beat_b;                       // Tail beat accepted

   assign frame_hi = (rx_frame_par == 8'hFF);
   assign beat_a   = (state == IDLE) && frame_hi && ecfg_rx_enable;
   assign beat_b   = (state == BEAT2) && frame_hi && ecfg_rx_enable;

   always_ff @(posedge rx_lclk_div4)
   begin
      if (reset)
      begin
         state        <= IDLE;
         emesh.access <= 1'b0;
      end
      else
      begin
         emesh.access <= 1'b0;              // Strobe lasts one cycle
         case (state)
            IDLE:
               if (frame_hi)
                  state <= beat_a ? BEAT2 : GAP; // Disabled frames are skipped whole
            BEAT2:
               if (beat_b)
               begin
                  state        <= GAP;
                  emesh.access <= 1'b1;     // Packet complete
               end
               else if (frame_hi)
                  state <= GAP;             // Enable dropped mid-packet
               else
                  state <= IDLE;            // Short frame, discard
            GAP:
               if (!frame_hi)
                  state <= IDLE;            // Need a low cycle between packets
            default:
               state <= IDLE;
         endcase
      end
   end

   // Field capture, only meaningful with access
   always_ff @(posedge rx_lclk_div4)
   begin
      if (beat_a)
      begin
         emesh.write         <= rx_data_par[63];
         emesh.datamode      <= datamode_t'(rx_data_par[62:61]);
         emesh.ctrlmode      <= rx_data_par[60:57];  // Bit 56 is spare
         emesh.dstaddr       <= rx_data_par[55:24];
         emesh.data[31:8]    <= rx_data_par[23:0];
      end
      if (beat_b)
      begin
         emesh.data[7:0]     <= rx_data_par[63:56];
         emesh.srcaddr       <= rx_data_par[55:24];  // Low 3 bytes are pad
      end
   end

   // Wait levels toward the pins
   always_ff @(posedge rx_lclk_div4)
   begin
      if (reset)
      begin
         rx_wr_wait <= 1'b0;
         rx_rd_wait <= 1'b0;
      end
      else
      begin
         rx_wr_wait <= emesh_rx_wr_wait;
         rx_rd_wait <= emesh_rx_rd_wait;
      end
   end

endmodule

`default_nettype wire

// ==== erx_settings.svh ====
`ifndef ERX_SETTINGS_SVH
`define ERX_SETTINGS_SVH

// Queue sizing, shared by all three receive queues
`define ERX_FIFO_DEPTH     32      // Entries per queue
`define ERX_PROGFULL_LEVEL 28      // Occupancy that raises prog-full

// Transactions landing in this 1MB region are read responses
`define ERX_RR_ID          12'h810 // Compared against dstaddr[31:20]

// Translation table, one entry per dstaddr[31:28] value
`define ERX_MMU_ENTRIES    16

`endif

// ==== erx_vectors.txt ====
# All fields hex. C rx_enable mmu_enable | M entry din | R entry expected_dout | H hold(1)/release(0)
# P write datamode ctrlmode dstaddr data srcaddr queue(0 wr,1 rq,2 rr) expected_dstaddr count
C 1 0
P 1 2 0 80001000 11223344 00000000 0 80001000 1
P 0 2 5 80002000 00000000 81000040 1 80002000 1
P 1 2 3 81000040 cafef00d 00000000 2 81000040 1
P 1 0 f 00000004 000000a5 00000000 0 00000004 2
P 0 3 1 3fff0000 00000000 81012340 1 3fff0000 2
P 1 1 2 810abcd0 0000beef 00000000 2 810abcd0 2
P 1 3 8 8100ffff 5a5a5a5a 12345678 2 8100ffff 1
H 0
M 0 00000123
M 8 fffff810
M f 0000aabc
R 0 00000123
R 8 00000810
R f 00000abc
C 1 1
P 1 2 0 0ab12345 01020304 00000000 0 12312345 1
P 1 2 6 8ff00010 deadbeef 00000000 2 81000010 1
P 0 2 0 f0000020 00000000 81000100 1 abc00020 1
H 0
C 0 0
P 1 2 0 80001000 11111111 00000000 0 80001000 3
P 0 2 0 80002000 00000000 81000000 1 80002000 1
H 0
C 1 0
H 1
P 1 2 0 20000000 00000100 00000000 0 20000000 20
H 0
H 1
P 0 2 0 30000000 00000000 81000000 1 30000000 20
H 0

// ==== tb_erx.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "erx_settings.svh"

module tb_erx;

   localparam int EW = 103;                          // Queue entry width

   logic          rx_lclk_div4;
   logic          reset;
   logic          ecfg_rx_enable;
   logic          ecfg_rx_mmu_enable;
   logic [7:0]    rx_frame_par;
   logic [63:0]   rx_data_par;
   logic          mi_en;
   logic          mi_we;
   logic [3:0]    mi_addr;
   logic [31:0]   mi_din;
   logic [31:0]   mi_dout;
   logic          rx_wr_wait;
   logic          rx_rd_wait;
   logic          emwr_rd_en;
   logic          emrq_rd_en;
   logic          emrr_rd_en;
   logic          emwr_empty;
   logic          emrq_empty;
   logic          emrr_empty;
   logic [EW-1:0] emwr_data;
   logic [EW-1:0] emrq_data;
   logic [EW-1:0] emrr_data;

   logic [EW-1:0] exp_wr [$];                        // Expected entries per queue
   logic [EW-1:0] exp_rq [$];
   logic [EW-1:0] exp_rr [$];
   logic          hold;                              // Pauses the drain process
   logic          records_known;
   int            num_records;
   int            errors;
   int            checks;
   int            compared;
   int            fd;
   int            r;
   logic [7:0]    kind;                              // Record letter
   logic [8*128-1:0] line;
   logic [31:0]   f0, f1, f2, f3, f4, f5, f6, f7, f8;

   erx dut0 (
      .rx_lclk_div4       (rx_lclk_div4),
      .reset              (reset),
      .ecfg_rx_enable     (ecfg_rx_enable),
      .ecfg_rx_mmu_enable (ecfg_rx_mmu_enable),
      .rx_frame_par       (rx_frame_par),
      .rx_data_par        (rx_data_par),
      .mi_en              (mi_en),
      .mi_we              (mi_we),
      .mi_addr            (mi_addr),
      .mi_din             (mi_din),
      .mi_dout            (mi_dout),
      .rx_wr_wait         (rx_wr_wait),
      .rx_rd_wait         (rx_rd_wait),
      .emaxi_emwr_rd_en   (emwr_rd_en),
      .emaxi_emwr_empty   (emwr_empty),
      .emaxi_emwr_rd_data (emwr_data),
      .emaxi_emrq_rd_en   (emrq_rd_en),
      .emaxi_emrq_empty   (emrq_empty),
      .emaxi_emrq_rd_data (emrq_data),
      .esaxi_emrr_rd_en   (emrr_rd_en),
      .esaxi_emrr_empty   (emrr_empty),
      .esaxi_emrr_rd_data (emrr_data)
   );

   always #20 rx_lclk_div4 = ~rx_lclk_div4;         // 40 ns period

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] want);
      checks = checks + 1;
      if (got !== want)
      begin
         errors = errors + 1;
         $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, want);
      end
   endtask

   function automatic int queue_size(input logic [31:0] qsel);
      case (qsel)
         0:       return exp_wr.size();
         1:       return exp_rq.size();
         default: return exp_rr.size();
      endcase
   endfunction

   // Head of a DUT queue against the oldest expected entry
   task automatic compare_head(input int qsel, input logic [EW-1:0] got);
      logic [EW-1:0] want;
      string         name;
      want = '0;
      case (qsel)
         0:       name = "emaxi_emwr_rd_data";
         1:       name = "emaxi_emrq_rd_data";
         default: name = "esaxi_emrr_rd_data";
      endcase
      if (queue_size(qsel) == 0)
      begin
         errors = errors + 1;
         $display("ERROR: unexpected entry %h at %0t in %s", got, $time, name);
      end
      else
      begin
         case (qsel)
            0:       want = exp_wr.pop_front();
            1:       want = exp_rq.pop_front();
            default: want = exp_rr.pop_front();
         endcase
         checks   = checks + 1;
         compared = compared + 1;
         if (got !== want)
         begin
            errors = errors + 1;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, want);
         end
      end
   endtask

   // Consumer pops at most one entry per queue each cycle
   always @(negedge rx_lclk_div4)
   begin
      emwr_rd_en = 1'b0;
      emrq_rd_en = 1'b0;
      emrr_rd_en = 1'b0;
      if (!hold)
      begin
         if (!emwr_empty)
         begin
            compare_head(0, emwr_data);
            emwr_rd_en = 1'b1;
         end
         if (!emrq_empty)
         begin
            compare_head(1, emrq_data);
            emrq_rd_en = 1'b1;
         end
         if (!emrr_empty)
         begin
            compare_head(2, emrr_data);
            emrr_rd_en = 1'b1;
         end
      end
   end

   // Two framed beats then one low cycle from falling edge to falling edge
   task automatic send_packet(input logic wr, input logic [1:0] dm, input logic [3:0] cm,
                              input logic [31:0] dst, input logic [31:0] dat,
                              input logic [31:0] src);
      rx_frame_par = 8'hFF;
      rx_data_par  = {wr, dm, cm, 1'b0, dst, dat[31:8]};   // Beat A
      @(negedge rx_lclk_div4);
      rx_data_par  = {dat[7:0], src, 24'd0};               // Beat B
      @(negedge rx_lclk_div4);
      rx_frame_par = 8'h00;
      rx_data_par  = 64'd0;
      @(negedge rx_lclk_div4);
   endtask

   task automatic run_packets(input logic [31:0] wr, dm, cm, dst, dat, src, qsel, exp_dst,
                              input logic [31:0] count);
      int            n;
      logic          stop;
      logic [EW-1:0] entry;
      stop = 1'b0;
      for (n = 0; n < count && !stop; n++)
      begin
         check_value("rx_wr_wait", rx_wr_wait, 0);        // Sender may start
         check_value("rx_rd_wait", rx_rd_wait, 0);
         entry = {wr[0], dm[1:0], cm[3:0], exp_dst, dat + n, src};
         if (ecfg_rx_enable)
         begin
            case (qsel)
               0:       exp_wr.push_back(entry);
               1:       exp_rq.push_back(entry);
               default: exp_rr.push_back(entry);
            endcase
         end
         send_packet(wr[0], dm[1:0], cm[3:0], dst, dat + n, src);
         if (hold && ecfg_rx_enable && queue_size(qsel) == `ERX_PROGFULL_LEVEL)
         begin
            if (qsel == 1)
               check_value("rx_rd_wait", rx_rd_wait, 0);  // Last entry not written yet
            else
               check_value("rx_wr_wait", rx_wr_wait, 0);
            repeat (3) @(negedge rx_lclk_div4);          // Two cycles after the entry lands
            if (qsel == 1)
            begin
               check_value("rx_rd_wait", rx_rd_wait, 1);
               check_value("rx_wr_wait", rx_wr_wait, 0);
            end
            else
            begin
               check_value("rx_wr_wait", rx_wr_wait, 1);
               check_value("rx_rd_wait", rx_rd_wait, 0);
            end
            stop = 1'b1;                                 // Sender backs off
         end
      end
   endtask

   task automatic table_write(input logic [3:0] addr, input logic [31:0] din);
      mi_en   = 1'b1;
      mi_we   = 1'b1;
      mi_addr = addr;
      mi_din  = din;
      @(negedge rx_lclk_div4);
      mi_en   = 1'b0;
      mi_we   = 1'b0;
   endtask

   task automatic table_read(input logic [3:0] addr, input logic [31:0] want);
      mi_en   = 1'b1;
      mi_we   = 1'b0;
      mi_addr = addr;
      @(negedge rx_lclk_div4);                           // mi_dout loaded at this edge
      mi_en   = 1'b0;
      check_value("mi_dout", mi_dout, want);
   endtask

   task automatic set_hold(input logic value);
      @(posedge rx_lclk_div4);
      hold = value;
      @(negedge rx_lclk_div4);
   endtask

   // Release the drain and expect idle queues with both waits low
   task automatic release_and_settle;
      int cycles;
      set_hold(1'b0);
      repeat (4) @(negedge rx_lclk_div4);                // Pipeline latency
      cycles = 0;
      while (exp_wr.size() + exp_rq.size() + exp_rr.size() != 0 && cycles < 200)
      begin
         @(negedge rx_lclk_div4);
         cycles = cycles + 1;
      end
      if (cycles >= 200)
      begin
         errors = errors + 1;
         $display("ERROR: queues did not drain by %0t, missing wr=%0d rq=%0d rr=%0d",
                  $time, exp_wr.size(), exp_rq.size(), exp_rr.size());
         exp_wr.delete();
         exp_rq.delete();
         exp_rr.delete();
      end
      repeat (2) @(negedge rx_lclk_div4);
      check_value("emaxi_emwr_empty", emwr_empty, 1);
      check_value("emaxi_emrq_empty", emrq_empty, 1);
      check_value("esaxi_emrr_empty", emrr_empty, 1);
      check_value("rx_wr_wait", rx_wr_wait, 0);
      check_value("rx_rd_wait", rx_rd_wait, 0);
   endtask

   task automatic finish_run;
      $display("Checks: %0d, entries compared: %0d, errors: %0d", checks, compared, errors);
      if (errors == 0)
         $display("SIMULATION PASSED");
      else
         $display("SIMULATION FAILED");
      $finish;
   endtask

   // Watchdog sized from the vector count
   initial
   begin
      wait (records_known);
      repeat (40 * num_records + 2000) @(posedge rx_lclk_div4);
      errors = errors + 1;
      $display("ERROR: timeout at %0t, vectors did not complete", $time);
      finish_run();
   end

   initial
   begin
      rx_lclk_div4       = 1'b0;
      reset              = 1'b1;
      ecfg_rx_enable     = 1'b0;
      ecfg_rx_mmu_enable = 1'b0;
      rx_frame_par       = 8'h00;
      rx_data_par        = 64'd0;
      mi_en              = 1'b0;
      mi_we              = 1'b0;
      mi_addr            = 4'd0;
      mi_din             = 32'd0;
      emwr_rd_en         = 1'b0;
      emrq_rd_en         = 1'b0;
      emrr_rd_en         = 1'b0;
      hold               = 1'b1;                         // No draining through reset
      records_known      = 1'b0;
      num_records        = 0;
      errors             = 0;
      checks             = 0;
      compared           = 0;
      fd = $fopen("erx_vectors.txt", "r");
      if (fd == 0)
      begin
         errors = errors + 1;
         $display("ERROR: cannot open erx_vectors.txt");
      end
      else
      begin
         while ($fscanf(fd, " %c", kind) == 1)           // Count records for the watchdog
         begin
            if (kind != "#")
               num_records = num_records + 1;
            r = $fgets(line, fd);
         end
         $fclose(fd);
         records_known = 1'b1;
         repeat (8) @(posedge rx_lclk_div4);
         @(negedge rx_lclk_div4);
         reset = 1'b0;
         @(negedge rx_lclk_div4);
         check_value("emaxi_emwr_empty", emwr_empty, 1);  // Reset state
         check_value("emaxi_emrq_empty", emrq_empty, 1);
         check_value("esaxi_emrr_empty", emrr_empty, 1);
         check_value("rx_wr_wait", rx_wr_wait, 0);
         check_value("rx_rd_wait", rx_rd_wait, 0);
         check_value("mi_dout", mi_dout, 0);
         set_hold(1'b0);
         fd = $fopen("erx_vectors.txt", "r");
         while ($fscanf(fd, " %c", kind) == 1)
         begin
            case (kind)
               "#": r = $fgets(line, fd);
               "C":
               begin
                  r = $fscanf(fd, "%h %h", f0, f1);
                  ecfg_rx_enable     = f0[0];
                  ecfg_rx_mmu_enable = f1[0];
               end
               "M":
               begin
                  r = $fscanf(fd, "%h %h", f0, f1);
                  table_write(f0[3:0], f1);
               end
               "R":
               begin
                  r = $fscanf(fd, "%h %h", f0, f1);
                  table_read(f0[3:0], f1);
               end
               "H":
               begin
                  r = $fscanf(fd, "%h", f0);
                  if (f0[0])
                     set_hold(1'b1);
                  else
                     release_and_settle();
               end
               "P":
               begin
                  r = $fscanf(fd, "%h %h %h %h %h %h %h %h %h",
                              f0, f1, f2, f3, f4, f5, f6, f7, f8);
                  run_packets(f0, f1, f2, f3, f4, f5, f6, f7, f8);
               end
               default:
               begin
                  errors = errors + 1;
                  $display("ERROR: unknown record type '%c' in erx_vectors.txt", kind);
                  r = $fgets(line, fd);
               end
            endcase
         end
         $fclose(fd);
      end
      finish_run();
   end

endmodule

`default_nettype wire
